/* files.f */
cache_pkg.sv
cache_tag_array.sv
cache_data_array.sv
cache_controller.sv
cache_toplevel.sv
tb_cache.sv

/* Makefile */
# Verilator build and run for the cache testbench

VERILATOR ?= verilator
TOP ?= tb_cache
FILE_LIST ?= files.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= *** TEST PASSED ***

SRCS := $(shell grep -v '^+' $(FILE_LIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)

# the simulator exit code is ignored, the log decides pass or fail
run: compile
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_cache.sv */
// directed testbench for the two-way cache, models main memory and checks against a reference model
`timescale 1ns/1ps

module tb_cache;

	localparam logic [31:0] seed = 32'hf009b82f;
	localparam int mem_size = 32768;		// 2**15 words
	localparam int num_ops = 19 + 200;		// directed accesses plus the random run
	localparam int worst_op_cycles = 8 * 8 + 16;	// 8 fill words at up to ~7 cycles each, plus slack
	localparam int cycle_limit = num_ops * worst_op_cycles + 20;

	logic clk;
	logic arst_n;
	logic cpu_req;
	cache_pkg::cpu_req_t cpu_cmd;
	logic cpu_ack;
	logic [cache_pkg::data_w-1:0] cpu_rdata;
	logic mem_req;
	cache_pkg::mem_req_t mem_cmd;
	logic mem_ack;
	logic [cache_pkg::data_w-1:0] mem_rdata;

	logic [cache_pkg::data_w-1:0] mem_words [mem_size];	// what the memory model holds
	logic [cache_pkg::data_w-1:0] gold [mem_size];	// expected memory image, updated by the stimulus
	logic [cache_pkg::mem_addr_w-1:0] rd_addr_q [$];	// read addresses seen during one access
	cache_pkg::mem_req_t last_wr;
	int rd_cnt = 0;
	int wr_cnt = 0;
	logic [31:0] stim_rng = seed;
	logic [31:0] dly_rng = seed;	// separate stream so delays don't shift stimulus

	// reference metadata, [way][set]
	logic ref_valid [2][cache_pkg::num_sets];
	logic ref_mru [2][cache_pkg::num_sets];
	logic [cache_pkg::tag_w-1:0] ref_tag [2][cache_pkg::num_sets];

	cache_toplevel i_cache_toplevel (
		.clk       (clk),
		.arst_n    (arst_n),
		.cpu_req   (cpu_req),
		.cpu_cmd   (cpu_cmd),
		.cpu_ack   (cpu_ack),
		.cpu_rdata (cpu_rdata),
		.mem_req   (mem_req),
		.mem_cmd   (mem_cmd),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;	// 8 ns period
	end

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic cache_pkg::cache_addr_t make_addr(input logic [cache_pkg::tag_w-1:0] tag,
		input logic [cache_pkg::set_w-1:0] set_idx, input logic [cache_pkg::word_w-1:0] word);
		cache_pkg::cache_addr_t a;
		a.tag = tag;
		a.set = set_idx;
		a.word = word;
		a.byte_off = 1'b0;	// word accesses only
		return a;
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at first error");
	endtask

	// memory side: answer each request after 1 to 4 cycles, data valid with mem_ack
	initial begin : mem_model
		int dly;
		cache_pkg::mem_req_t cmd;
		mem_ack = 1'b0;
		mem_rdata = '0;
		forever begin
			@(negedge clk);
			if (mem_req) begin
				cmd = mem_cmd;	// stable while mem_req is high
				dly_rng = lcg_step(dly_rng);
				dly = 1 + int'(dly_rng[17:16]);
				repeat (dly) @(posedge clk);
				if (cmd.write) begin
					mem_words[cmd.addr] = cmd.wdata;
					last_wr = cmd;
					wr_cnt++;
				end else begin
					mem_rdata <= mem_words[cmd.addr];
					rd_addr_q.push_back(cmd.addr);
					rd_cnt++;
				end
				mem_ack <= 1'b1;
				do @(negedge clk); while (mem_req);	// cache drops req after capture
				@(posedge clk);
				mem_ack <= 1'b0;
			end
		end
	end

	// one full cpu handshake, lat counts falling edges until ack is seen
	task automatic cpu_access(input logic wr, input cache_pkg::cache_addr_t a,
		input logic [15:0] wd, output logic [15:0] rd, output int lat);
		@(posedge clk);
		cpu_req <= 1'b1;
		cpu_cmd <= {wr, a, wd};
		lat = 0;
		do begin
			@(negedge clk);
			lat++;
		end while (!cpu_ack);
		rd = cpu_rdata;	// valid while ack is high
		@(posedge clk);
		cpu_req <= 1'b0;
		do @(negedge clk); while (cpu_ack);	// next request only after ack low
	endtask

	task automatic ref_lookup(input cache_pkg::cache_addr_t a, output logic h, output logic w);
		h = 1'b0;
		w = 1'b0;
		for (int i = 0; i < 2; i++) begin
			if (ref_valid[i][a.set] && ref_tag[i][a.set] == a.tag) begin
				h = 1'b1;
				w = 1'(i);
			end
		end
	endtask

	task automatic ref_touch(input logic [cache_pkg::set_w-1:0] s, input logic w);
		ref_mru[w][s] = 1'b1;
		ref_mru[~w][s] = 1'b0;
	endtask

	task automatic ref_fill(input cache_pkg::cache_addr_t a);
		logic v;
		if (!ref_valid[0][a.set]) v = 1'b0;	// first invalid way wins
		else if (!ref_valid[1][a.set]) v = 1'b1;
		else if (ref_mru[0][a.set] == ref_mru[1][a.set]) v = 1'b0;
		else v = ref_mru[0][a.set];	// the way whose mru is 0
		ref_valid[v][a.set] = 1'b1;
		ref_tag[v][a.set] = a.tag;
		ref_touch(a.set, v);
	endtask

	task automatic load_check(input cache_pkg::cache_addr_t a);
		logic exp_hit;
		logic way;
		logic [15:0] rd;
		int lat;
		int rd0;
		int wr0;
		logic [cache_pkg::mem_addr_w-1:0] wa;
		ref_lookup(a, exp_hit, way);
		rd0 = rd_cnt;
		wr0 = wr_cnt;
		rd_addr_q.delete();
		cpu_access(1'b0, a, 16'h0000, rd, lat);
		wa = {a.tag, a.set, a.word};
		assert (rd == gold[wa]) else stop_on_error($sformatf(
			"Mismatch at %0t: load %h returned %h, expected %h", $time, a, rd, gold[wa]));
		assert (wr_cnt == wr0) else stop_on_error("a load wrote to main memory");
		if (exp_hit) begin
			assert (rd_cnt == rd0) else stop_on_error($sformatf(
				"Mismatch at %0t: load %h expected hit, saw %0d reads", $time, a, rd_cnt - rd0));
			// second falling edge = ack 1 cycle after the edge that sampled req
			assert (lat == 2) else stop_on_error($sformatf(
				"Mismatch at %0t: hit latency %0d edges, expected 2", $time, lat));
			ref_touch(a.set, way);
		end else begin
			assert (rd_cnt - rd0 == 8) else stop_on_error($sformatf(
				"Mismatch at %0t: load %h expected miss, saw %0d reads", $time, a, rd_cnt - rd0));
			for (int k = 0; k < 8; k++) begin
				assert (rd_addr_q[k] == {a.tag, a.set, 3'(k)}) else stop_on_error($sformatf(
					"Mismatch at %0t: fill read %0d at %h", $time, k, rd_addr_q[k]));
			end
			ref_fill(a);
		end
	endtask

	// hand derived hit or miss on top of the reference check
	task automatic load_expect(input cache_pkg::cache_addr_t a, input logic exp_hit);
		int rd0;
		rd0 = rd_cnt;
		load_check(a);
		assert ((rd_cnt - rd0) == (exp_hit ? 0 : 8)) else stop_on_error($sformatf(
			"Mismatch at %0t: load %h hit expected %0b", $time, a, exp_hit));
	endtask

	task automatic store_check(input cache_pkg::cache_addr_t a, input logic [15:0] d);
		logic exp_hit;
		logic way;
		logic [15:0] rd;
		int lat;
		int rd0;
		int wr0;
		logic [cache_pkg::mem_addr_w-1:0] wa;
		ref_lookup(a, exp_hit, way);
		rd0 = rd_cnt;
		wr0 = wr_cnt;
		cpu_access(1'b1, a, d, rd, lat);
		wa = {a.tag, a.set, a.word};
		assert (wr_cnt == wr0 + 1 && rd_cnt == rd0) else stop_on_error($sformatf(
			"Mismatch at %0t: store made %0d writes, %0d reads", $time, wr_cnt - wr0, rd_cnt - rd0));
		assert (last_wr.addr == wa && last_wr.wdata == d) else stop_on_error($sformatf(
			"Mismatch at %0t: write-through %h=%h, expected %h=%h", $time,
			last_wr.addr, last_wr.wdata, wa, d));
		gold[wa] = d;
		if (exp_hit) ref_touch(a.set, way);	// no allocate on a store miss
	endtask

	task automatic test_reset_miss();
		load_expect(make_addr(6'h0a, 6'd3, 3'd5), 1'b0);
	endtask

	task automatic test_hit_block();
		for (int w = 0; w < 8; w++) load_expect(make_addr(6'h0a, 6'd3, 3'(w)), 1'b1);
	endtask

	task automatic test_stores();
		store_check(make_addr(6'h0a, 6'd3, 3'd2), 16'hbeef);	// cached word
		load_expect(make_addr(6'h0a, 6'd3, 3'd2), 1'b1);
		store_check(make_addr(6'h21, 6'd40, 3'd1), 16'h1234);	// uncached, no allocate
		load_expect(make_addr(6'h21, 6'd40, 3'd1), 1'b0);
	endtask

	task automatic test_replacement();
		load_expect(make_addr(6'h01, 6'd12, 3'd0), 1'b0);	// A
		load_expect(make_addr(6'h02, 6'd12, 3'd3), 1'b0);	// B
		load_expect(make_addr(6'h01, 6'd12, 3'd4), 1'b1);	// A again, B now lru
		load_expect(make_addr(6'h03, 6'd12, 3'd7), 1'b0);	// C evicts B
		load_expect(make_addr(6'h01, 6'd12, 3'd1), 1'b1);
		load_expect(make_addr(6'h02, 6'd12, 3'd3), 1'b0);
	endtask

	task automatic test_random();
		logic [31:0] r;
		cache_pkg::cache_addr_t a;
		for (int n = 0; n < 200; n++) begin
			stim_rng = lcg_step(stim_rng);
			r = stim_rng;
			// 4 tags over 4 sets keeps both ways busy
			a = make_addr(6'(r[31:30]), 6'd20 + 6'(r[29:28]), r[27:25]);
			if (r[24:22] < 3'd3) store_check(a, r[15:0]);
			else load_check(a);
		end
	endtask

	initial begin : stimulus
		arst_n = 1'b0;
		cpu_req = 1'b0;
		cpu_cmd = '0;
		for (int i = 0; i < mem_size; i++) begin
			stim_rng = lcg_step(stim_rng);
			mem_words[i] = stim_rng[31:16] ^ 16'(i);	// address folded in
			gold[i] = mem_words[i];
		end
		for (int s = 0; s < cache_pkg::num_sets; s++) begin
			for (int w = 0; w < 2; w++) begin
				ref_valid[w][s] = 1'b0;
				ref_mru[w][s] = 1'b0;
				ref_tag[w][s] = '0;
			end
		end
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		assert (cpu_ack === 1'b0 && mem_req === 1'b0) else
			stop_on_error("cpu_ack or mem_req not low after reset");
		test_reset_miss();
		test_hit_block();
		test_stores();
		test_replacement();
		test_random();
		$display("*** TEST PASSED ***");
		$finish;
	end

	initial begin : watchdog
		int cycle_cnt;
		cycle_cnt = 0;
		while (cycle_cnt < cycle_limit) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: tests did not finish within %0d cycles", cycle_limit);
		$display("*** TEST FAILED ***");
		$fatal(1, "timeout");
	end

endmodule

/* cache_toplevel.sv */
// two-way read-allocate write-through cache top level, connect to cpu and main memory req/ack ports
`timescale 1ns/1ps

module cache_toplevel (
	input logic clk,
	input logic arst_n,
	// cpu side
	input logic cpu_req,
	input cache_pkg::cpu_req_t cpu_cmd,
	output logic cpu_ack,
	output logic [cache_pkg::data_w-1:0] cpu_rdata,
	// main memory side
	output logic mem_req,
	output cache_pkg::mem_req_t mem_cmd,
	input logic mem_ack,
	input logic [cache_pkg::data_w-1:0] mem_rdata
);

	cache_pkg::cache_addr_t addr;
	cache_pkg::meta_t meta_rd [cache_pkg::num_ways];	// entry of each way at addr.set
	cache_pkg::meta_t meta_wr [cache_pkg::num_ways];	// next entry under the update rule

	logic [cache_pkg::num_ways-1:0] way_hit;
	logic hit;
	logic hit_way;
	logic victim_way;
	logic upd_way;			// way that becomes mru on this meta write

	// controller outputs
	logic data_we;
	logic data_sel_fill;
	logic fill_way;
	logic [cache_pkg::word_w-1:0] fill_word;
	logic meta_we;
	logic meta_fill;
	logic mem_write;
	logic [cache_pkg::word_w-1:0] mem_word;

	// data array address and write data after the cpu / fill mux
	logic arr_way;
	logic [cache_pkg::word_w-1:0] arr_word;
	logic [cache_pkg::data_w-1:0] arr_wdata;

	assign addr = cpu_cmd.addr;

	// lookup: tag compare against both valid ways
	assign hit = |way_hit;
	assign hit_way = way_hit[1];	// at most one way hits

	// victim: first invalid way, then the non-mru way, way 0 on a tie
	assign victim_way = meta_rd[0].valid
		&& (!meta_rd[1].valid || (meta_rd[0].mru && !meta_rd[1].mru));

	// hit touch and fill both make exactly one way mru
	assign upd_way = meta_fill ? fill_way : hit_way;

	for (genvar w = 0; w < cache_pkg::num_ways; w++) begin : g_way
		assign way_hit[w] = meta_rd[w].valid && (meta_rd[w].tag == addr.tag);

		// filled way takes the new tag, valid and mru; otherwise only mru moves
		assign meta_wr[w] = (meta_fill && (fill_way == 1'(w)))
			? cache_pkg::meta_t'{valid: 1'b1, mru: 1'b1, tag: addr.tag}
			: cache_pkg::meta_t'{valid: meta_rd[w].valid,
				mru: (upd_way == 1'(w)), tag: meta_rd[w].tag};

		// both ways written together since the partner's mru changes too
		cache_tag_array i_tag_array (
			.clk    (clk),
			.arst_n (arst_n),
			.set    (addr.set),
			.we     (meta_we),
			.wdata  (meta_wr[w]),
			.rdata  (meta_rd[w])
		);
	end

	// fill owns way/word/data, else the cpu request addresses the array
	assign arr_way = data_sel_fill ? fill_way : hit_way;
	assign arr_word = data_sel_fill ? fill_word : addr.word;
	assign arr_wdata = data_sel_fill ? mem_rdata : cpu_cmd.wdata;

	cache_data_array i_data_array (
		.clk   (clk),
		.way   (arr_way),
		.set   (addr.set),
		.word  (arr_word),
		.we    (data_we),
		.wdata (arr_wdata),
		.rdata (cpu_rdata)		// read at hit way, valid while cpu_ack is high
	);

	cache_controller i_controller (
		.clk           (clk),
		.arst_n        (arst_n),
		.cpu_req       (cpu_req),
		.cpu_write     (cpu_cmd.write),
		.cpu_ack       (cpu_ack),
		.hit           (hit),
		.victim_way    (victim_way),
		.data_we       (data_we),
		.data_sel_fill (data_sel_fill),
		.fill_way      (fill_way),
		.fill_word     (fill_word),
		.meta_we       (meta_we),
		.meta_fill     (meta_fill),
		.mem_req       (mem_req),
		.mem_ack       (mem_ack),
		.mem_write     (mem_write),
		.mem_word      (mem_word)
	);

	// memory word address: fill counts through the block, a store uses its own word
	assign mem_cmd.write = mem_write;
	assign mem_cmd.addr = {addr.tag, addr.set, mem_write ? addr.word : mem_word};
	assign mem_cmd.wdata = cpu_cmd.wdata;

	// a tag lives in at most one way of a set, fills only go to a missing tag
	a_one_way_hits: assert property (@(posedge clk) disable iff (!arst_n)
		cpu_req |-> !(way_hit[0] && way_hit[1]));

endmodule

/* cache_controller.sv */
// cache FSM, sequences cpu and memory req/ack handshakes, block fill with tag-last commit and write-through
`timescale 1ns/1ps

module cache_controller (
	input logic clk,
	input logic arst_n,
	// cpu side
	input logic cpu_req,
	input logic cpu_write,
	output logic cpu_ack,
	// lookup results from the toplevel
	input logic hit,
	input logic victim_way,
	// array controls
	output logic data_we,
	output logic data_sel_fill,			// 1 = array address and data come from the fill
	output logic fill_way,
	output logic [cache_pkg::word_w-1:0] fill_word,
	output logic meta_we,
	output logic meta_fill,			// 1 = commit the filled line, 0 = mru touch on hit
	// memory side
	output logic mem_req,
	input logic mem_ack,
	output logic mem_write,
	output logic [cache_pkg::word_w-1:0] mem_word
);

	enum logic [2:0] {
		st_idle,
		st_fill_req,		// read request out, waiting for mem_ack
		st_fill_low,		// word captured, waiting for mem_ack to drop
		st_commit,		// tag write, line becomes valid here
		st_respond,		// load done, data on cpu_rdata
		st_wr_req,		// write-through request out
		st_wr_low,
		st_ack			// store done
	} state, state_nxt;

	logic [cache_pkg::word_w-1:0] fill_cnt;	// next block word to fetch
	logic miss_start;

	assign miss_start = (state == st_idle) && cpu_req && !cpu_write && !hit;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			fill_way <= 1'b0;
			fill_cnt <= '0;
		end else begin
			state <= state_nxt;
			if (miss_start) begin
				fill_way <= victim_way;	// frozen for the whole fill
				fill_cnt <= '0;		// block always fetched from word 0
			end else if (state == st_fill_low && !mem_ack) begin
				fill_cnt <= fill_cnt + 1'b1;	// wraps to 0 after word 7, unused then
			end
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				if (cpu_req) begin
					if (cpu_write) begin
						state_nxt = st_wr_req;		// hit or not, memory gets the word
					end else if (hit) begin
						state_nxt = st_respond;	// mru written on this edge
					end else begin
						state_nxt = st_fill_req;
					end
				end
			end
			st_fill_req: begin
				if (mem_ack) state_nxt = st_fill_low;
			end
			st_fill_low: begin
				if (!mem_ack) begin
					// all 8 words in the array, tag may go in now
					state_nxt = (&fill_cnt) ? st_commit : st_fill_req;
				end
			end
			st_commit: state_nxt = st_respond;	// lookup hits next cycle
			st_respond: begin
				if (!cpu_req) state_nxt = st_idle;	// cpu holds req, ack stays up
			end
			st_wr_req: begin
				if (mem_ack) state_nxt = st_wr_low;
			end
			st_wr_low: begin
				if (!mem_ack) state_nxt = st_ack;
			end
			st_ack: begin
				if (!cpu_req) state_nxt = st_idle;
			end
			default: state_nxt = st_idle;
		endcase
	end

	// handshake outputs straight from state, low in idle and after reset
	assign cpu_ack = (state == st_respond) || (state == st_ack);
	assign mem_req = (state == st_fill_req) || (state == st_wr_req);
	assign mem_write = (state == st_wr_req);
	assign mem_word = fill_cnt;	// only used for reads, stores take the cpu word

	// fill path owns the array from first request through the commit
	assign data_sel_fill = (state == st_fill_req) || (state == st_fill_low)
		|| (state == st_commit);
	assign fill_word = fill_cnt;

	// fill word lands on the edge that sees mem_ack, store hit in the first cycle
	assign data_we = ((state == st_fill_req) && mem_ack)
		|| ((state == st_idle) && cpu_req && cpu_write && hit);

	// every hit touches mru in idle, the commit writes the new line
	assign meta_we = (state == st_commit) || ((state == st_idle) && cpu_req && hit);
	assign meta_fill = (state == st_commit);

	// ack only answers a pending request
	a_ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(cpu_ack) |-> cpu_req);

endmodule

/* cache_data_array.sv */
// data store for both ways, 128 blocks of 8 words, combinational read and one word written per clock
`timescale 1ns/1ps

module cache_data_array (
	input logic clk,
	input logic way,				// way 1 sits 64 blocks above way 0
	input logic [cache_pkg::set_w-1:0] set,
	input logic [cache_pkg::word_w-1:0] word,
	input logic we,
	input logic [cache_pkg::data_w-1:0] wdata,
	output logic [cache_pkg::data_w-1:0] rdata
);

	localparam int depth = cache_pkg::num_ways * cache_pkg::num_sets
		* cache_pkg::words_per_block;

	// contents only matter once the tag commit marks a line valid
	logic [cache_pkg::data_w-1:0] mem [depth];

	// flat word index: {way, set, word}, 10 bits
	logic [$clog2(depth)-1:0] idx;

	assign idx = {way, set, word};

	always_ff @(posedge clk) begin
		if (we) begin
			mem[idx] <= wdata;	// fill word or store hit
		end
	end

	assign rdata = mem[idx];	// valid in the same cycle as the address

	// way comes from hit or victim logic, set from the cpu request
	a_wr_addr_known: assert property (@(posedge clk)
		we |-> !$isunknown({way, set, word}));

endmodule

/* cache_tag_array.sv */
// metadata store for one cache way, 64 entries of valid/mru/tag read combinationally per set
`timescale 1ns/1ps

module cache_tag_array (
	input logic clk,
	input logic arst_n,
	input logic [cache_pkg::set_w-1:0] set,	// set index of the current request
	input logic we,				// write the addressed entry this edge
	input cache_pkg::meta_t wdata,
	output cache_pkg::meta_t rdata
);

	// flop based so that every entry can be cleared on reset
	cache_pkg::meta_t entry [cache_pkg::num_sets];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			// whole entry goes to zero, way starts invalid and cold
			for (int i = 0; i < cache_pkg::num_sets; i++) begin
				entry[i] <= '0;
			end
		end else if (we) begin
			entry[set] <= wdata;	// single entry update, valid/mru/tag together
		end
	end

	// read is combinational so hit detection sees the tag in the request cycle
	assign rdata = entry[set];

	// a committed line must carry a real tag, else later lookups hit on garbage
	a_valid_tag_known: assert property (@(posedge clk) disable iff (!arst_n)
		we && wdata.valid |-> !$isunknown({set, wdata.tag}));

endmodule

/* cache_pkg.sv */
// shared cache geometry and packed request types, referenced by scoped name from RTL and testbench
package cache_pkg;

	// address split: [15:10] tag, [9:4] set, [3:1] word, [0] byte
	localparam int tag_w = 6;
	localparam int set_w = 6;
	localparam int num_sets = 64;		// 2**set_w
	localparam int word_w = 3;
	localparam int words_per_block = 8;	// 2**word_w
	localparam int data_w = 16;
	localparam int num_ways = 2;

	// main memory is word addressed, so the byte bit drops off
	localparam int mem_addr_w = tag_w + set_w + word_w;

	// cpu byte address as the cache sees it
	typedef struct packed {
		logic [tag_w-1:0] tag;		// compared against both ways
		logic [set_w-1:0] set;		// picks one entry per way
		logic [word_w-1:0] word;	// word within the 8-word block
		logic byte_off;			// ignored, word accesses only
	} cache_addr_t;

	// one metadata entry per way and set
	// mru = 1 means this way was touched after its partner
	typedef struct packed {
		logic valid;
		logic mru;
		logic [tag_w-1:0] tag;
	} meta_t;

	// cpu request word, held stable while cpu_req is high
	typedef struct packed {
		logic write;			// 1 = store, 0 = load
		cache_addr_t addr;
		logic [data_w-1:0] wdata;	// store data, don't care on loads
	} cpu_req_t;

	// main memory request word, held stable while mem_req is high
	typedef struct packed {
		logic write;				// 1 = write-through word
		logic [mem_addr_w-1:0] addr;		// word address {tag, set, word}
		logic [data_w-1:0] wdata;
	} mem_req_t;

endpackage
